// File: rtl/spi_reg_pkg.sv
package spi_reg_pkg;

  // frame geometry
  localparam int FRAME_BITS = 32;      // bits per spi frame
  localparam int HDR_BITS   = 8;       // read flag plus address
  localparam int DATA_BITS  = 24;      // register width
  localparam int UPD_BITS   = 12;      // set and clear field width
  localparam int ADDR_BITS  = 7;       // msb = update mode, low 6 = register

  // register numbers within the low 6 address bits
  localparam int REG_LED     = 7;
  localparam int REG_SPI_MUX = 8;
  localparam int REG_4094    = 9;

  localparam logic [DATA_BITS-1:0] LED_RESET     = 24'hAAAAAA; // alternating test pattern
  localparam logic [DATA_BITS-1:0] BAD_ADDR_DATA = 24'd12345;  // answer for unknown address

  localparam int SR_BIT_CYCLES = 4;    // cs cycles per 4094 serial bit

  // one 32-bit frame word, decoded by the update-mode address bit
  typedef union packed {
    struct packed {
      logic                 rd;          // 1 = read, writes suppressed
      logic [ADDR_BITS-1:0] addr;
      logic [DATA_BITS-1:0] data;        // plain write value
    } wr;
    struct packed {
      logic                 rd;
      logic [ADDR_BITS-1:0] addr;
      logic [UPD_BITS-1:0]  set_bits;    // bits to set
      logic [UPD_BITS-1:0]  clr_bits;    // bits to clear
    } upd;
  } spi_frame_u;

  // per bit: set and clear together toggles, clear beats set, else keep
  function automatic logic [UPD_BITS-1:0] bit_update(input logic [UPD_BITS-1:0] old_val,
                                                     input logic [UPD_BITS-1:0] set_bits,
                                                     input logic [UPD_BITS-1:0] clr_bits);
    logic [UPD_BITS-1:0] only_set;
    logic [UPD_BITS-1:0] only_clr;
    logic [UPD_BITS-1:0] both;
    only_set = set_bits & ~clr_bits;
    only_clr = clr_bits & ~set_bits;
    both     = set_bits & clr_bits;
    return ((old_val | only_set) & ~only_clr) ^ both;
  endfunction

endpackage

// File: rtl/spi_frame_shifter.sv
`timescale 1ns/1ns

module spi_frame_shifter (
  input  logic                                     cs,
  input  logic                                     reset,
  input  logic                                     sclk,
  input  logic                                     ss_n,
  input  logic                                     mosi,
  output logic                                     miso,
  output logic                                     hdr_valid,
  output logic [spi_reg_pkg::ADDR_BITS-1:0]        hdr_addr,
  input  logic [spi_reg_pkg::DATA_BITS-1:0]        rd_data,
  output logic                                     frame_valid,
  output spi_reg_pkg::spi_frame_u                  frame
);

  logic [2:0] sclk_sync;   // [1:0] synchronizer, [2] edge history
  logic [2:0] ss_sync;
  logic [1:0] mosi_sync;   // same depth as sclk so data lines up with the edge

  logic sclk_rise;
  logic sclk_fall;
  logic ss_rise;
  logic ss_fall;
  logic active;            // chip select low after sync
  logic reply_shift;       // falling edge in the data phase

  logic [5:0]                            bit_cnt;   // rising sclk edges in this frame
  logic [spi_reg_pkg::FRAME_BITS-1:0]    frame_sr;  // mosi shift register
  logic [spi_reg_pkg::DATA_BITS-1:0]     reply;     // readback word going out on miso

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      ss_sync   <= '1;     // idle deselected, no false falling edge
      mosi_sync <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      ss_sync   <= {ss_sync[1:0], ss_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise   = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall   = ~sclk_sync[1] & sclk_sync[2];
  assign ss_rise     = ss_sync[1] & ~ss_sync[2];
  assign ss_fall     = ~ss_sync[1] & ss_sync[2];
  assign active      = ~ss_sync[1];
  assign reply_shift = active & sclk_fall & (bit_cnt >= spi_reg_pkg::HDR_BITS);

  // control path
  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      bit_cnt     <= '0;
      hdr_valid   <= 1'b0;
      frame_valid <= 1'b0;
      miso        <= 1'b0;
    end
    else
    begin
      hdr_valid   <= active & sclk_rise & (bit_cnt == spi_reg_pkg::HDR_BITS - 1); // 8th bit in
      frame_valid <= ss_rise & (bit_cnt == spi_reg_pkg::FRAME_BITS); // other counts dropped
      if (ss_fall)
        bit_cnt <= '0;                         // new frame
      else if (active && sclk_rise)
        bit_cnt <= bit_cnt + 6'd1;
      if (!active)
        miso <= 1'b0;                          // quiet while deselected
      else if (reply_shift)
        miso <= reply[spi_reg_pkg::DATA_BITS-1]; // msb first, host samples on next rise
    end
  end

  // payload path
  always_ff @(posedge cs)
  begin
    if (active && sclk_rise)
      frame_sr <= {frame_sr[spi_reg_pkg::FRAME_BITS-2:0], mosi_sync[1]};
    if (hdr_valid)
      reply <= rd_data;                        // bank answers for hdr_addr this cycle
    else if (reply_shift)
      reply <= {reply[spi_reg_pkg::DATA_BITS-2:0], 1'b0};
  end

  // after 8 bits the low byte is rd flag + address, low 7 bits are the address
  assign hdr_addr = frame_sr[spi_reg_pkg::ADDR_BITS-1:0];
  assign frame    = frame_sr;

  // header pulse needs sclk activity with select low, frame pulse needs select rising
  a_hdr_frame_excl: assert property (@(posedge cs) disable iff (reset)
    !(hdr_valid && frame_valid));

  // host never clocks more than 63 bits into one frame
  a_cnt_no_wrap: assert property (@(posedge cs) disable iff (reset)
    (active && sclk_rise) |-> (bit_cnt != 6'd63));

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ns

module reg_bank (
  input  logic                              cs,
  input  logic                              reset,
  input  logic [spi_reg_pkg::ADDR_BITS-1:0] hdr_addr,
  output logic [spi_reg_pkg::DATA_BITS-1:0] rd_data,
  input  logic                              frame_valid,
  input  spi_reg_pkg::spi_frame_u           frame,
  output logic [spi_reg_pkg::DATA_BITS-1:0] led,
  output logic [spi_reg_pkg::DATA_BITS-1:0] spi_mux,
  output logic [spi_reg_pkg::DATA_BITS-1:0] sr_state
);

  logic [spi_reg_pkg::ADDR_BITS-2:0] wr_sel;  // register number of the finished frame
  logic                              wr_ok;   // complete frame, write flavour
  logic                              we_led;
  logic                              we_mux;
  logic                              we_4094;

  // new register value: plain write, or bit update of the low 12 bits
  function automatic logic [spi_reg_pkg::DATA_BITS-1:0] apply_frame(
    input logic [spi_reg_pkg::DATA_BITS-1:0] old_val,
    input spi_reg_pkg::spi_frame_u           f
  );
    logic [spi_reg_pkg::UPD_BITS-1:0] low_new;
    low_new = spi_reg_pkg::bit_update(old_val[spi_reg_pkg::UPD_BITS-1:0],
                                      f.upd.set_bits, f.upd.clr_bits);
    if (f.wr.addr[spi_reg_pkg::ADDR_BITS-1])
      return {old_val[spi_reg_pkg::DATA_BITS-1:spi_reg_pkg::UPD_BITS], low_new};
    else
      return f.wr.data;
  endfunction

  assign wr_sel  = frame.wr.addr[spi_reg_pkg::ADDR_BITS-2:0];  // mode bit ignored for select
  assign wr_ok   = frame_valid & ~frame.wr.rd;                 // read flag blocks writes
  assign we_led  = wr_ok & (wr_sel == spi_reg_pkg::REG_LED);
  assign we_mux  = wr_ok & (wr_sel == spi_reg_pkg::REG_SPI_MUX);
  assign we_4094 = wr_ok & (wr_sel == spi_reg_pkg::REG_4094);
  // unknown addresses match no enable and are dropped

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      led      <= spi_reg_pkg::LED_RESET;
      spi_mux  <= '0;                       // no spi device selected
      sr_state <= '0;
    end
    else
    begin
      if (we_led)
        led <= apply_frame(led, frame);
      if (we_mux)
        spi_mux <= apply_frame(spi_mux, frame);
      if (we_4094)
        sr_state <= apply_frame(sr_state, frame);
    end
  end

  // readback for the header just received, same decode as the writes
  always_comb
  begin
    case (hdr_addr[spi_reg_pkg::ADDR_BITS-2:0])
      spi_reg_pkg::REG_LED:
      begin
        rd_data = led;
      end
      spi_reg_pkg::REG_SPI_MUX:
      begin
        rd_data = spi_mux;
      end
      spi_reg_pkg::REG_4094:
      begin
        rd_data = sr_state;
      end
      default:
      begin
        rd_data = spi_reg_pkg::BAD_ADDR_DATA;   // marker value the host can recognise
      end
    endcase
  end

  // one frame addresses one register
  a_one_we: assert property (@(posedge cs) disable iff (reset)
    $onehot0({we_led, we_mux, we_4094}));

endmodule

// File: rtl/sr4094_driver.sv
`timescale 1ns/1ns

module sr4094_driver (
  input  logic                              cs,
  input  logic                              reset,
  input  logic [spi_reg_pkg::DATA_BITS-1:0] sr_state,
  output logic                              sr_clk,
  output logic                              sr_data,
  output logic                              sr_strobe,
  output logic                              sr_oe
);

  logic [spi_reg_pkg::DATA_BITS-1:0]             last_sent;  // value of the current or last shift
  logic [spi_reg_pkg::DATA_BITS-1:0]             shift_q;    // msb goes out on sr_data
  logic                                          pending;    // forces the first ship after reset
  logic                                          shifting;
  logic                                          strobing;
  logic [$clog2(spi_reg_pkg::DATA_BITS)-1:0]     bit_cnt;
  logic [$clog2(spi_reg_pkg::SR_BIT_CYCLES)-1:0] phase;      // cycle within a bit or strobe
  logic                                          bit_done;
  logic                                          start;

  assign bit_done = shifting & (phase == spi_reg_pkg::SR_BIT_CYCLES - 1);
  // idle and something new to ship; a change during a shift waits until here
  assign start    = ~shifting & ~strobing & (pending | (sr_state != last_sent));

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      pending  <= 1'b1;
      shifting <= 1'b0;
      strobing <= 1'b0;
      bit_cnt  <= '0;
      phase    <= '0;
      sr_oe    <= 1'b0;
    end
    else if (shifting)
    begin
      phase <= bit_done ? '0 : phase + 1'b1;
      if (bit_done)
      begin
        if (bit_cnt == spi_reg_pkg::DATA_BITS - 1)
        begin
          shifting <= 1'b0;                 // last bit clocked, latch the chain
          strobing <= 1'b1;
          bit_cnt  <= '0;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else if (strobing)
    begin
      if (phase == 1)                       // two-cycle strobe
      begin
        phase    <= '0;
        strobing <= 1'b0;
        sr_oe    <= 1'b1;                   // outputs valid from the first latch on
      end
      else
        phase <= phase + 1'b1;
    end
    else if (start)
    begin
      pending  <= 1'b0;
      shifting <= 1'b1;
      phase    <= '0;
      bit_cnt  <= '0;
    end
  end

  always_ff @(posedge cs)
  begin
    if (start)
    begin
      last_sent <= sr_state;                // newest value only
      shift_q   <= sr_state;
    end
    else if (bit_done)
      shift_q <= {shift_q[spi_reg_pkg::DATA_BITS-2:0], 1'b0};
  end

  assign sr_data   = shifting & shift_q[spi_reg_pkg::DATA_BITS-1];
  assign sr_clk    = shifting & (phase >= spi_reg_pkg::SR_BIT_CYCLES - 2); // high last 2 cycles
  assign sr_strobe = strobing;

  // latching while the chain is still clocking would capture a half-shifted word
  a_strobe_no_clk: assert property (@(posedge cs) disable iff (reset)
    !(sr_strobe && sr_clk));

endmodule

// File: rtl/spi_reg_top.sv
`timescale 1ns/1ns

module spi_reg_top (
  input  logic                              cs,
  input  logic                              reset,
  input  logic                              sclk,       // spi pins, mode 0
  input  logic                              ss_n,
  input  logic                              mosi,
  output logic                              miso,
  output logic [spi_reg_pkg::DATA_BITS-1:0] led,
  output logic [spi_reg_pkg::DATA_BITS-1:0] spi_mux,
  output logic                              sr_clk,     // 4094 chain
  output logic                              sr_data,
  output logic                              sr_strobe,
  output logic                              sr_oe
);

  logic                              hdr_valid;
  logic [spi_reg_pkg::ADDR_BITS-1:0] hdr_addr;
  logic [spi_reg_pkg::DATA_BITS-1:0] rd_data;   // combinational readback
  logic                              frame_valid;
  spi_reg_pkg::spi_frame_u           frame;
  logic [spi_reg_pkg::DATA_BITS-1:0] sr_state;  // 4094 register into the driver

  spi_frame_shifter u_shifter (
    .cs          (cs),
    .reset       (reset),
    .sclk        (sclk),
    .ss_n        (ss_n),
    .mosi        (mosi),
    .miso        (miso),
    .hdr_valid   (hdr_valid),
    .hdr_addr    (hdr_addr),
    .rd_data     (rd_data),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  reg_bank u_bank (
    .cs          (cs),
    .reset       (reset),
    .hdr_addr    (hdr_addr),
    .rd_data     (rd_data),
    .frame_valid (frame_valid),
    .frame       (frame),
    .led         (led),
    .spi_mux     (spi_mux),
    .sr_state    (sr_state)
  );

  sr4094_driver u_driver (
    .cs          (cs),
    .reset       (reset),
    .sr_state    (sr_state),
    .sr_clk      (sr_clk),
    .sr_data     (sr_data),
    .sr_strobe   (sr_strobe),
    .sr_oe       (sr_oe)
  );

endmodule

// File: sim/tb_spi_reg.sv
`timescale 1ns/1ns

module tb_spi_reg;

  localparam logic [5:0] NUM_LED = 6'(spi_reg_pkg::REG_LED);
  localparam logic [5:0] NUM_MUX = 6'(spi_reg_pkg::REG_SPI_MUX);
  localparam logic [5:0] NUM_SR  = 6'(spi_reg_pkg::REG_4094);
  localparam logic [5:0] NUM_BAD = 6'd20;           // no register here

  localparam int FRAME_CYCLES = 14 + 32 * 8;        // select setup, 8 cycles per bit, settle
  localparam int NUM_FRAMES   = 28;                 // upper bound over all tests
  localparam int QUIET_CYCLES = 200;                // strobe-free time, driver is idle
  localparam int QUIET_WAITS  = 3;
  localparam int TIMEOUT_NS   = 2 * 10 * (10 + NUM_FRAMES * FRAME_CYCLES
                                          + QUIET_WAITS * (QUIET_CYCLES + 110)); // 2x margin

  logic        cs;
  logic        reset;
  logic        sclk;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  logic [23:0] led;
  logic [23:0] spi_mux;
  logic        sr_clk;
  logic        sr_data;
  logic        sr_strobe;
  logic        sr_oe;

  logic [23:0] chain;                               // external 4094 chain
  logic [23:0] chain_latched;                       // 4094 output latches
  logic [23:0] exp_led;                             // expected register contents
  logic [23:0] exp_mux;
  logic [23:0] exp_sr;
  int          errors;
  int          checks;

  spi_reg_top dut0 (
    .cs        (cs),
    .reset     (reset),
    .sclk      (sclk),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .miso      (miso),
    .led       (led),
    .spi_mux   (spi_mux),
    .sr_clk    (sr_clk),
    .sr_data   (sr_data),
    .sr_strobe (sr_strobe),
    .sr_oe     (sr_oe)
  );

  always #5 cs = ~cs;                               // 10 ns system clock

  always @(posedge sr_clk)
    chain <= {chain[22:0], sr_data};                // msb ends up at the far end
  always @(posedge sr_strobe)
    chain_latched <= chain;

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #1;                                             // drive just after the edge
  endtask

  task automatic check_eq(input logic [23:0] got, input logic [23:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // mode 0 host, 4 cycles low and 4 high per bit, miso taken on the rising edge
  task automatic spi_xfer(input logic [31:0] word, input int nbits, output logic [23:0] rx);
    rx   = '0;
    ss_n = 1'b0;
    wait_cycles(2);
    for (int i = 0; i < nbits; i++)
    begin
      mosi = word[31 - i];                          // msb first, changes with falling sclk
      wait_cycles(4);
      sclk = 1'b1;
      if (i >= 8)
        rx = {rx[22:0], miso};                      // reply follows the header
      wait_cycles(4);
      sclk = 1'b0;
    end
    wait_cycles(4);
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(8);                                 // frame pulse and register update
  endtask

  task automatic write_reg(input logic [5:0] num, input logic [23:0] data);
    logic [23:0] rx;
    spi_xfer({1'b0, 1'b0, num, data}, 32, rx);
  endtask

  task automatic update_reg(input logic [5:0] num, input logic [11:0] set_f,
                            input logic [11:0] clr_f);
    logic [23:0] rx;
    spi_xfer({1'b0, 1'b1, num, set_f, clr_f}, 32, rx); // address msb selects update mode
  endtask

  task automatic read_reg(input logic [5:0] num, output logic [23:0] data);
    spi_xfer({1'b1, 1'b0, num, 24'h0}, 32, data);
  endtask

  // both fields toggle, clear beats set, otherwise the bit stays
  function automatic logic [23:0] upd_expect(input logic [23:0] old_val,
                                             input logic [11:0] set_f,
                                             input logic [11:0] clr_f);
    logic [23:0] res;
    res = old_val;                                  // top 12 bits never touched
    for (int b = 0; b < 12; b++)
    begin
      if (set_f[b] && clr_f[b])
        res[b] = ~old_val[b];
      else if (clr_f[b])
        res[b] = 1'b0;
      else if (set_f[b])
        res[b] = 1'b1;
    end
    return res;
  endfunction

  // wait until neither sr_clk nor sr_strobe has moved for a while
  task automatic wait_chain_quiet();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES)
    begin
      @(negedge cs);                                // driver outputs settled by now
      if (sr_strobe || sr_clk)
        quiet = 0;
      else
        quiet++;
    end
    wait_cycles(1);
  endtask

  task automatic test_reset_values();
    logic [23:0] rx;
    exp_led = 24'hAAAAAA;                           // alternating reset pattern
    exp_mux = '0;
    exp_sr  = '0;
    read_reg(NUM_LED, rx);
    check_eq(rx, exp_led, "led readback after reset");
    read_reg(NUM_MUX, rx);
    check_eq(rx, exp_mux, "spi_mux readback after reset");
    read_reg(NUM_SR, rx);
    check_eq(rx, exp_sr, "4094 readback after reset");
    check_eq(led, exp_led, "led port after reset");
    wait_chain_quiet();                             // reset value shipped once
    check_eq(24'(sr_oe), 24'd1, "sr_oe after first strobe");
    check_eq(chain_latched, 24'h0, "4094 chain after reset");
  endtask

  task automatic test_writes();
    logic [23:0] rx;
    exp_led = 24'($urandom());
    exp_mux = 24'($urandom());
    exp_sr  = 24'($urandom());
    write_reg(NUM_LED, exp_led);
    write_reg(NUM_MUX, exp_mux);
    write_reg(NUM_SR, exp_sr);
    read_reg(NUM_LED, rx);
    check_eq(rx, exp_led, "led readback after write");
    read_reg(NUM_MUX, rx);
    check_eq(rx, exp_mux, "spi_mux readback after write");
    read_reg(NUM_SR, rx);
    check_eq(rx, exp_sr, "4094 readback after write");
    check_eq(led, exp_led, "led port after write");
    check_eq(spi_mux, exp_mux, "spi_mux port after write");
    wait_chain_quiet();
    check_eq(chain_latched, exp_sr, "4094 chain after write");
  endtask

  task automatic test_bit_update();
    logic [23:0] rx;
    logic [11:0] set_f;
    logic [11:0] clr_f;
    for (int n = 0; n < 2; n++)
    begin
      set_f   = 12'($urandom());
      clr_f   = 12'($urandom());
      exp_led = upd_expect(exp_led, set_f, clr_f);
      update_reg(NUM_LED, set_f, clr_f);
      read_reg(NUM_LED, rx);
      check_eq(rx, exp_led, "led readback after bit update");
    end
    check_eq(led, exp_led, "led port after bit update");
    set_f   = 12'($urandom());
    clr_f   = 12'($urandom());
    exp_mux = upd_expect(exp_mux, set_f, clr_f);
    update_reg(NUM_MUX, set_f, clr_f);
    read_reg(NUM_MUX, rx);
    check_eq(rx, exp_mux, "spi_mux readback after bit update");
  endtask

  task automatic test_bad_address();
    logic [23:0] rx;
    read_reg(NUM_BAD, rx);
    check_eq(rx, 24'd12345, "readback of unknown address");
    spi_xfer({1'b1, 1'b0, NUM_LED, ~exp_led}, 32, rx); // read flag plus data
    check_eq(rx, exp_led, "reply to read frame with data");
    read_reg(NUM_LED, rx);
    check_eq(rx, exp_led, "led after read frame with data");
    write_reg(NUM_BAD, 24'h5A5A5A);                 // goes nowhere
    check_eq(led, exp_led, "led port after write to unknown address");
    check_eq(spi_mux, exp_mux, "spi_mux port after write to unknown address");
    read_reg(NUM_SR, rx);
    check_eq(rx, exp_sr, "4094 readback after write to unknown address");
  endtask

  task automatic test_short_frame();
    logic [23:0] rx;
    // rd flag left off, so a wrongly taken frame would be a write to spi_mux
    spi_xfer({1'b0, NUM_MUX, ~exp_mux, 1'b0}, 31, rx);
    check_eq(spi_mux, exp_mux, "spi_mux port after short frame");
    read_reg(NUM_MUX, rx);
    check_eq(rx, exp_mux, "spi_mux readback after short frame");
  endtask

  task automatic test_fast_4094();
    logic [23:0] rx;
    logic [23:0] first;
    first  = 24'($urandom());
    exp_sr = 24'($urandom());
    write_reg(NUM_SR, first);
    write_reg(NUM_SR, exp_sr);                      // lands while the first may still ship
    wait_chain_quiet();
    check_eq(chain_latched, exp_sr, "4094 chain after back to back writes");
    check_eq(24'(sr_oe), 24'd1, "sr_oe stays high");
    read_reg(NUM_SR, rx);
    check_eq(rx, exp_sr, "4094 readback after back to back writes");
  endtask

  initial
  begin
    void'($urandom(18170));                         // one seed for the whole run
    errors        = 0;
    checks        = 0;
    cs            = 1'b0;
    reset         = 1'b1;
    sclk          = 1'b0;
    ss_n          = 1'b1;                           // host idle
    mosi          = 1'b0;
    chain         = '0;
    chain_latched = '1;                             // only a real strobe clears this
    repeat (10) @(posedge cs);
    #1;
    reset = 1'b0;
    test_reset_values();
    test_writes();
    test_bit_update();
    test_bad_address();
    test_short_frame();
    test_fast_4094();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: tests still running after %0d ns, run stopped", TIMEOUT_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: spi_reg.f
rtl/spi_reg_pkg.sv
rtl/spi_frame_shifter.sv
rtl/reg_bank.sv
rtl/sr4094_driver.sv
rtl/spi_reg_top.sv
sim/tb_spi_reg.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f spi_reg.f --top-module tb_spi_reg \
  -Mdir obj_dir -o Vtb_spi_reg && ./obj_dir/Vtb_spi_reg > sim.log 2>&1 || \
  { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
